/* logic/core_settings.svh */
// sizes assume a 32-bit RV32I core; the CSR bank is one contiguous block of machine CSRs
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data word width
`define CORE_XLEN 32

// machine scratch block starting at mscratch
`define CSR_BASE 12'h340
`define CSR_COUNT 4

`endif

/* logic/riscv_isa_pkg.sv */
// RV32I base encodings and Zicsr register forms only; no compressed or extension opcodes
`default_nettype none

package riscv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 of OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct3 of CSR register forms
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // selects SUB and SRA
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, read through the view its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

`default_nettype wire

/* logic/riscv_ctrl_pkg.sv */
// control types of a two-stage execute cluster; no memory stages, traps or stall
`default_nettype none

`include "core_settings.svh"

package riscv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_SEQ, ALU_SNEQ,
        ALU_SLT, ALU_SLTU,
        ALU_SGE, ALU_SGEU,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_src_e;

    typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_PC_INC, OP2_CSR} op2_src_e;

    typedef enum logic [1:0] {BNJ_NONE, BNJ_JAL, BNJ_JALR, BNJ_BRANCH} bnj_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

    // instruction strobe into the cluster
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instr;
    } instr_in_t;

    // ID/EX register
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [4:0]            rs1_addr;
        logic [`CORE_XLEN-1:0] rs1_data;
        logic [4:0]            rs2_addr;
        logic [`CORE_XLEN-1:0] rs2_data;
        logic [`CORE_XLEN-1:0] imm;
        op1_src_e              op1_src;
        op2_src_e              op2_src;
        alu_op_e               alu_op;
        bnj_e                  bnj;
        csr_op_e               csr_op;
        logic [11:0]           csr_addr;
        logic                  write_rd;
        logic [4:0]            rd;
    } idex_t;

    // EX/MEM register, also the retire port and the regfile write port
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic                  write_rd;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] data;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* logic/regfile.sv */
// 31 registers plus hard-wired x0; a write in the same cycle is visible on both read ports
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module regfile (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    output logic [`CORE_XLEN-1:0]   rs1_data_o,
    output logic [`CORE_XLEN-1:0]   rs2_data_o,
    input  riscv_ctrl_pkg::retire_t wr_i
);

    logic [`CORE_XLEN-1:0] regs_q [1:31];
    logic                  wr_en;

    assign wr_en = wr_i.valid && wr_i.write_rd && (wr_i.rd != 5'd0);

    // x0, then write-through, then the array
    function automatic logic [`CORE_XLEN-1:0] read_port(input logic [4:0] addr);
        logic [`CORE_XLEN-1:0] data;
        if (addr == 5'd0)
            data = '0;
        else if (wr_en && addr == wr_i.rd)
            data = wr_i.data;
        else
            data = regs_q[addr];
        return data;
    endfunction

    always_comb
    begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end
        else if (wr_en)
        begin
            regs_q[wr_i.rd] <= wr_i.data;
        end
    end

endmodule

`default_nettype wire

/* logic/csr_bank.sv */
// CSR_COUNT contiguous CSRs from CSR_BASE; other addresses read zero and drop writes
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module csr_bank (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [11:0]             addr_i,
    output logic [`CORE_XLEN-1:0]   rdata_o,
    input  riscv_ctrl_pkg::csr_op_e op_i,
    input  logic [`CORE_XLEN-1:0]   wdata_i
);
    import riscv_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`CSR_COUNT);

    logic [`CORE_XLEN-1:0] csr_q [`CSR_COUNT];
    logic [11:0]           offset;
    logic                  in_bank;
    logic [IDX_W-1:0]      idx;
    logic [`CORE_XLEN-1:0] next_val;

    // below the base wraps around and fails the range check
    assign offset  = addr_i - `CSR_BASE;
    assign in_bank = offset < 12'(`CSR_COUNT);
    assign idx     = offset[IDX_W-1:0];
    assign rdata_o = in_bank ? csr_q[idx] : '0;

    always_comb
    begin
        case (op_i)
            CSR_WRITE: next_val = wdata_i;
            CSR_SET:   next_val = rdata_o | wdata_i;
            CSR_CLEAR: next_val = rdata_o & ~wdata_i;
            default:   next_val = rdata_o;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `CSR_COUNT; i++)
                csr_q[i] <= '0;
        end
        else if (in_bank && op_i != CSR_NONE)
        begin
            csr_q[idx] <= next_val;
        end
    end

endmodule

`default_nettype wire

/* logic/decode.sv */
// one-cycle decode of RV32I and CSR register forms; other words become entries that write no rd
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module decode (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  riscv_ctrl_pkg::instr_in_t instr_i,
    input  logic                      kill_i,
    output logic [4:0]                rs1_addr_o,
    output logic [4:0]                rs2_addr_o,
    input  logic [`CORE_XLEN-1:0]     rs1_data_i,
    input  logic [`CORE_XLEN-1:0]     rs2_data_i,
    output riscv_ctrl_pkg::idex_t     idex_o
);
    import riscv_isa_pkg::*;
    import riscv_ctrl_pkg::*;

    instr_u                word;
    idex_t                 idex_d;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_j;

    // shared by OP and OP_IMM with alt picking SUB or SRA
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign word = instr_i.instr;

    assign rs1_addr_o = word.r.rs1;
    assign rs2_addr_o = word.r.rs2;

    // sign-extended immediates
    assign imm_i = {{20{word.i.imm[11]}}, word.i.imm};
    assign imm_b = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                    word.b.imm10_5, word.b.imm4_1, 1'b0};
    assign imm_u = {word.u.imm, 12'd0};
    assign imm_j = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                    word.j.imm11, word.j.imm10_1, 1'b0};

    always_comb
    begin
        idex_d          = '0;
        // the shadow of a taken branch enters as a bubble
        idex_d.valid    = instr_i.valid && !kill_i;
        idex_d.pc       = instr_i.pc;
        idex_d.rs1_addr = word.r.rs1;
        idex_d.rs1_data = rs1_data_i;
        idex_d.rs2_addr = word.r.rs2;
        idex_d.rs2_data = rs2_data_i;
        idex_d.rd       = word.r.rd;
        idex_d.csr_addr = word.i.imm;
        idex_d.op1_src  = OP1_RS1;
        idex_d.op2_src  = OP2_RS2;
        idex_d.alu_op   = ALU_ADD;
        idex_d.bnj      = BNJ_NONE;
        idex_d.csr_op   = CSR_NONE;

        case (word.r.opcode)
            OPC_OP:
            begin
                idex_d.write_rd = 1'b1;
                idex_d.alu_op   = arith_op(word.r.funct3, word.r.funct7 == F7_ALT);
            end
            OPC_OP_IMM:
            begin
                idex_d.write_rd = 1'b1;
                idex_d.op2_src  = OP2_IMM;
                idex_d.imm      = imm_i;
                idex_d.alu_op   = arith_op(word.r.funct3,
                                           word.r.funct3 == F3_SR && word.r.funct7 == F7_ALT);
            end
            OPC_LUI, OPC_AUIPC:
            begin
                idex_d.write_rd = 1'b1;
                idex_d.op1_src  = (word.r.opcode == OPC_LUI) ? OP1_ZERO : OP1_PC;
                idex_d.op2_src  = OP2_IMM;
                idex_d.imm      = imm_u;
            end
            OPC_JAL, OPC_JALR:
            begin
                // link value pc+4 comes out of the ALU
                idex_d.write_rd = 1'b1;
                idex_d.op1_src  = OP1_PC;
                idex_d.op2_src  = OP2_PC_INC;
                idex_d.bnj      = (word.r.opcode == OPC_JAL) ? BNJ_JAL : BNJ_JALR;
                idex_d.imm      = (word.r.opcode == OPC_JAL) ? imm_j : imm_i;
            end
            OPC_BRANCH:
            begin
                idex_d.imm = imm_b;
                idex_d.bnj = BNJ_BRANCH;
                case (word.b.funct3)
                    F3_BEQ:  idex_d.alu_op = ALU_SEQ;
                    F3_BNE:  idex_d.alu_op = ALU_SNEQ;
                    F3_BLT:  idex_d.alu_op = ALU_SLT;
                    F3_BGE:  idex_d.alu_op = ALU_SGE;
                    F3_BLTU: idex_d.alu_op = ALU_SLTU;
                    F3_BGEU: idex_d.alu_op = ALU_SGEU;
                    default: idex_d.bnj    = BNJ_NONE;
                endcase
            end
            OPC_SYSTEM:
            begin
                // rd takes the old CSR value through 0 + csr
                idex_d.op1_src = OP1_ZERO;
                idex_d.op2_src = OP2_CSR;
                idex_d.write_rd = word.i.funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC};
                case (word.i.funct3)
                    F3_CSRRW: idex_d.csr_op = CSR_WRITE;
                    F3_CSRRS: idex_d.csr_op = CSR_SET;
                    F3_CSRRC: idex_d.csr_op = CSR_CLEAR;
                    default:  idex_d.csr_op = CSR_NONE;
                endcase
            end
            default:
            begin
                // unknown word retires without a register write
                idex_d.write_rd = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            idex_o <= '0;
        end
        else
        begin
            idex_o <= idex_d;
        end
    end

endmodule

`default_nettype wire

/* logic/execute.sv */
// single forward source is the EX/MEM register; branch shadow is killed in decode, no stall
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module execute (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  riscv_ctrl_pkg::idex_t     idex_i,
    output logic                      kill_o,
    output logic [11:0]               csr_addr_o,
    input  logic [`CORE_XLEN-1:0]     csr_rdata_i,
    output riscv_ctrl_pkg::csr_op_e   csr_op_o,
    output logic [`CORE_XLEN-1:0]     csr_wdata_o,
    output riscv_ctrl_pkg::retire_t   retire_o,
    output riscv_ctrl_pkg::redirect_t redirect_o
);
    import riscv_ctrl_pkg::*;

    logic                  fwd_ok;
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] op1;
    logic [`CORE_XLEN-1:0] op2;
    logic                  sub_en;
    logic                  cmp_signed;
    logic [`CORE_XLEN:0]   sum;
    logic                  is_eq;
    logic                  is_ge;
    logic                  cmp_res;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] target;
    logic                  bnj_hit;

    // forward from the instruction one ahead
    assign fwd_ok  = retire_o.valid && retire_o.write_rd && (retire_o.rd != 5'd0);
    assign rs1_val = (fwd_ok && retire_o.rd == idex_i.rs1_addr) ? retire_o.data : idex_i.rs1_data;
    assign rs2_val = (fwd_ok && retire_o.rd == idex_i.rs2_addr) ? retire_o.data : idex_i.rs2_data;

    always_comb
    begin
        case (idex_i.op1_src)
            OP1_RS1: op1 = rs1_val;
            OP1_PC:  op1 = idex_i.pc;
            default: op1 = '0;
        endcase

        case (idex_i.op2_src)
            OP2_RS2:    op2 = rs2_val;
            OP2_IMM:    op2 = idex_i.imm;
            OP2_PC_INC: op2 = `CORE_XLEN'(4);
            OP2_CSR:    op2 = csr_rdata_i;
        endcase
    end

    // one adder for add, subtract and every compare
    assign sub_en = idex_i.alu_op inside {ALU_SUB, ALU_SEQ, ALU_SNEQ, ALU_SLT,
                                          ALU_SLTU, ALU_SGE, ALU_SGEU};
    assign cmp_signed = idex_i.alu_op inside {ALU_SLT, ALU_SGE};
    assign sum = {1'b0, op1} + {1'b0, sub_en ? ~op2 : op2} + {{`CORE_XLEN{1'b0}}, sub_en};

    assign is_eq = (sum[`CORE_XLEN-1:0] == '0);

    always_comb
    begin
        // the non-negative side is larger when the signs differ
        if (cmp_signed && (op1[`CORE_XLEN-1] != op2[`CORE_XLEN-1]))
            is_ge = ~op1[`CORE_XLEN-1];
        else if (cmp_signed)
            is_ge = ~sum[`CORE_XLEN-1];
        else
            // carry out of a + ~b + 1
            is_ge = sum[`CORE_XLEN];
    end

    always_comb
    begin
        case (idex_i.alu_op)
            ALU_SEQ:           cmp_res = is_eq;
            ALU_SNEQ:          cmp_res = ~is_eq;
            ALU_SGE, ALU_SGEU: cmp_res = is_ge;
            default:           cmp_res = ~is_ge;
        endcase
    end

    always_comb
    begin
        case (idex_i.alu_op)
            ALU_ADD, ALU_SUB: alu_res = sum[`CORE_XLEN-1:0];
            ALU_XOR:          alu_res = op1 ^ op2;
            ALU_OR:           alu_res = op1 | op2;
            ALU_AND:          alu_res = op1 & op2;
            ALU_SLL:          alu_res = op1 << op2[4:0];
            ALU_SRL:          alu_res = op1 >> op2[4:0];
            ALU_SRA:          alu_res = $signed(op1) >>> op2[4:0];
            default:          alu_res = {{(`CORE_XLEN-1){1'b0}}, cmp_res};
        endcase
    end

    // branch and jump resolution
    always_comb
    begin
        bnj_hit = 1'b0;
        target  = idex_i.pc + idex_i.imm;
        case (idex_i.bnj)
            BNJ_JAL:
            begin
                bnj_hit = 1'b1;
            end
            BNJ_JALR:
            begin
                bnj_hit = 1'b1;
                target  = (rs1_val + idex_i.imm) & ~`CORE_XLEN'(1);
            end
            BNJ_BRANCH:
            begin
                bnj_hit = cmp_res;
            end
            default:
            begin
                bnj_hit = 1'b0;
            end
        endcase
    end

    assign kill_o = idex_i.valid && bnj_hit;

    // CSR bank commits on the same edge as EX/MEM
    assign csr_addr_o  = idex_i.csr_addr;
    assign csr_op_o    = idex_i.valid ? idex_i.csr_op : CSR_NONE;
    assign csr_wdata_o = rs1_val;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            retire_o   <= '0;
            redirect_o <= '0;
        end
        else
        begin
            retire_o.valid    <= idex_i.valid;
            retire_o.pc       <= idex_i.pc;
            retire_o.write_rd <= idex_i.valid && idex_i.write_rd;
            retire_o.rd       <= idex_i.rd;
            retire_o.data     <= alu_res;
            redirect_o.valid  <= kill_o;
            redirect_o.target <= target;
        end
    end

endmodule

`default_nettype wire

/* logic/ex_cluster_top.sv */
// fixed two-cycle latency from strobe to retire; no fetch, no back-pressure, no loads or stores
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module ex_cluster_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  riscv_ctrl_pkg::instr_in_t instr_i,
    output riscv_ctrl_pkg::retire_t   retire_o,
    output riscv_ctrl_pkg::redirect_t redirect_o
);
    import riscv_ctrl_pkg::*;

    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    idex_t                 idex;
    logic                  kill;
    logic [11:0]           csr_addr;
    logic [`CORE_XLEN-1:0] csr_rdata;
    csr_op_e               csr_op;
    logic [`CORE_XLEN-1:0] csr_wdata;

    decode u_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .instr_i    (instr_i),
        .kill_i     (kill),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .idex_o     (idex)
    );

    // written straight from the retire port
    regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (retire_o)
    );

    execute u_execute (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .idex_i      (idex),
        .kill_o      (kill),
        .csr_addr_o  (csr_addr),
        .csr_rdata_i (csr_rdata),
        .csr_op_o    (csr_op),
        .csr_wdata_o (csr_wdata),
        .retire_o    (retire_o),
        .redirect_o  (redirect_o)
    );

    csr_bank u_csr_bank (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .addr_i  (csr_addr),
        .rdata_o (csr_rdata),
        .op_i    (csr_op),
        .wdata_i (csr_wdata)
    );

endmodule

`default_nettype wire

/* test/ex_cluster_chk.sv */
// bound to ex_cluster_top; kill_i is the top's internal kill strobe from execute
`default_nettype none
`timescale 1ns/10ps

module ex_cluster_chk (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  riscv_ctrl_pkg::instr_in_t instr_i,
    input  logic                      kill_i,
    input  riscv_ctrl_pkg::retire_t   retire_i,
    input  riscv_ctrl_pkg::redirect_t redirect_i
);

    // two-cycle latency from strobe to retire
    retire_has_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_i.valid |-> $past(instr_i.valid, 2))
    else $error("retire without a strobe two cycles earlier");

    // instruction behind a taken branch or jump
    shadow_no_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        kill_i |-> ##2 !retire_i.valid)
    else $error("shadow of a redirect retired");

    reset_clears_valid: assert property (@(posedge clk_i)
        !rst_n_i |-> (!retire_i.valid && !redirect_i.valid))
    else $error("valid flags not cleared in reset");

endmodule

bind ex_cluster_top ex_cluster_chk u_ex_cluster_chk (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .instr_i    (instr_i),
    .kill_i     (kill),
    .retire_i   (retire_o),
    .redirect_i (redirect_o)
);

`default_nettype wire

/* test/ex_cluster_tb.sv */
// reads test/ex_cluster_stimulus.txt from the project root; NUM_LINES must match its line count
`default_nettype none
`timescale 1ns/10ps

module ex_cluster_tb;
    import riscv_ctrl_pkg::*;

    localparam int NUM_LINES      = 41;
    localparam int WORDS_PER_LINE = 8;
    localparam int TIMEOUT_CYCLES = NUM_LINES + 2 + 10;

    logic        clk_i;
    logic        rst_n_i;
    instr_in_t   instr_i;
    retire_t     retire_o;
    redirect_t   redirect_o;
    logic [31:0] stim [0:NUM_LINES*WORDS_PER_LINE-1];
    int          cycle_count;

    ex_cluster_top u_ex_cluster_top (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .instr_i    (instr_i),
        .retire_o   (retire_o),
        .redirect_o (redirect_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "mismatch");
        end
    endtask

    // kind 0 no retire, 1 rd write, 2 no rd write, 3 write to x0 with data unchecked
    task automatic check_line(input int idx);
        int          base;
        logic [31:0] kind;
        string       tag;
        base = idx * WORDS_PER_LINE;
        kind = stim[base+3];
        tag  = $sformatf("line %0d", idx);
        check_value({tag, " retire valid"}, {31'd0, kind != 0}, {31'd0, retire_o.valid});
        if (kind != 0)
        begin
            check_value({tag, " retire pc"}, stim[base+1], retire_o.pc);
            check_value({tag, " write rd"}, {31'd0, kind == 1 || kind == 3},
                        {31'd0, retire_o.write_rd});
        end
        if (kind == 1 || kind == 3)
            check_value({tag, " rd"}, stim[base+4], {27'd0, retire_o.rd});
        if (kind == 1)
            check_value({tag, " data"}, stim[base+5], retire_o.data);
        check_value({tag, " redirect valid"}, {31'd0, stim[base+6][0]},
                    {31'd0, redirect_o.valid});
        if (stim[base+6][0])
            check_value({tag, " redirect target"}, stim[base+7], redirect_o.target);
    endtask

    task automatic drive_line(input int idx);
        int base;
        base = idx * WORDS_PER_LINE;
        if (idx < NUM_LINES)
        begin
            instr_i.valid <= stim[base][0];
            instr_i.pc    <= stim[base+1];
            instr_i.instr <= stim[base+2];
        end
        else
        begin
            // drain cycles
            instr_i <= '0;
        end
    endtask

    // run limit counted in cycles after reset
    always @(posedge clk_i)
    begin
        if (rst_n_i)
        begin
            cycle_count = cycle_count + 1;
            if (cycle_count > TIMEOUT_CYCLES)
            begin
                $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
                $display("sim failed");
                $fatal(1, "timeout");
            end
        end
    end

    initial
    begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        instr_i     = '0;
        cycle_count = 0;
        $readmemh("test/ex_cluster_stimulus.txt", stim);

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // results of line c show up two edges after it is driven
        for (int c = 0; c < NUM_LINES + 2; c++)
        begin
            @(posedge clk_i);
            drive_line(c);
            @(negedge clk_i);
            if (c >= 2)
                check_line(c - 2);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/riscv_isa_pkg.sv
logic/riscv_ctrl_pkg.sv
logic/regfile.sv
logic/csr_bank.sv
logic/decode.sv
logic/execute.sv
logic/ex_cluster_top.sv
test/ex_cluster_chk.sv
test/ex_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module ex_cluster_tb \
    -Mdir obj_dir -o ex_cluster_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/ex_cluster_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator returned status $sim_status"
    exit 1
fi
exit 0

/* test/ex_cluster_stimulus.txt */
// strobe pc instr | retire kind (0 none, 1 rd write, 2 no write, 3 x0) rd data
// | redirect valid target; all hex, one line per cycle
1 00000100 00500093 1 01 00000005 0 00000000
1 00000104 FFD00113 1 02 FFFFFFFD 0 00000000
1 00000108 002081B3 1 03 00000002 0 00000000
1 0000010C 40118233 1 04 FFFFFFFD 0 00000000
1 00000110 40125293 1 05 FFFFFFFE 0 00000000
1 00000114 00425313 1 06 0FFFFFFF 0 00000000
1 00000118 00309393 1 07 00000028 0 00000000
1 0000011C 0013C433 1 08 0000002D 0 00000000
1 00000120 10046493 1 09 0000012D 0 00000000
1 00000124 0F04F513 1 0A 00000020 0 00000000
1 00000128 00708013 3 00 00000000 0 00000000
1 0000012C 001005B3 1 0B 00000005 0 00000000
1 00000130 00112633 1 0C 00000001 0 00000000
1 00000134 001136B3 1 0D 00000000 0 00000000
1 00000138 12345737 1 0E 12345000 0 00000000
1 0000013C 00001797 1 0F 0000113C 0 00000000
1 00000140 00B08463 2 00 00000000 1 00000148
1 00000144 00100A13 0 00 00000000 0 00000000
1 00000148 00B09463 2 00 00000000 0 00000000
1 0000014C 00114463 2 00 00000000 1 00000154
1 00000150 00100A13 0 00 00000000 0 00000000
1 00000154 00115463 2 00 00000000 0 00000000
1 00000158 00116463 2 00 00000000 0 00000000
1 0000015C 00117463 2 00 00000000 1 00000164
1 00000160 00100A13 0 00 00000000 0 00000000
1 00000164 FE20D6E3 2 00 00000000 1 00000150
1 00000168 00100A13 0 00 00000000 0 00000000
1 00000150 00108813 1 10 00000006 0 00000000
1 00000154 00C008EF 1 11 00000158 1 00000160
1 00000158 00100A13 0 00 00000000 0 00000000
1 00000160 1FB80967 1 12 00000164 1 00000200
1 00000164 00100A13 0 00 00000000 0 00000000
1 00000200 340099F3 1 13 00000000 0 00000000
1 00000204 3403AAF3 1 15 00000005 0 00000000
1 00000208 3400BB73 1 16 0000002D 0 00000000
1 0000020C 34002BF3 1 17 00000028 0 00000000
1 00000210 30009C73 1 18 00000000 0 00000000
1 00000214 30002CF3 1 19 00000000 0 00000000
1 00000218 00000A8B 2 00 00000000 0 00000000
1 0000021C 000A8D33 1 1A 00000005 0 00000000
0 00000000 00000000 0 00 00000000 0 00000000
